// File: miner_ctrl.f
miner_ctrl_pkg.sv
uart_rx.sv
byte_timeout.sv
receiver.sv
nonce_register.sv
status_reply.sv
miner_ctrl_top.sv
miner_ctrl_tb.sv

// File: Makefile
TOP = miner_ctrl_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f miner_ctrl.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f miner_ctrl.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir

// File: miner_ctrl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module miner_ctrl_tb;

	localparam int BIT_CLKS = 8;
	localparam int TMO_CLKS = 400;
	localparam int RESET_CLKS = 10;
	localparam int MAX_TESTS = 24;
	localparam int MAX_LEN = 8;
	localparam int NONCE_W = miner_ctrl_pkg::NONCE_BYTES * 8;

	logic clk_i;
	logic rst_i;
	logic rx;
	logic tx;
	logic running;
	logic nonce_valid;
	logic [NONCE_W-1:0] nonce;

	// One table row per command sequence.
	logic [7:0] seq [MAX_TESTS][MAX_LEN];
	int seq_len [MAX_TESTS];
	int gap [MAX_TESTS];
	int gap_at [MAX_TESTS];
	logic exp_run [MAX_TESTS];
	logic exp_has_nonce [MAX_TESTS];
	logic [NONCE_W-1:0] exp_nonce [MAX_TESTS];
	logic exp_has_reply [MAX_TESTS];
	logic [7:0] exp_reply [MAX_TESTS];
	int num_tests = 0;

	int checks = 0;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;
	int nonce_count = 0;
	int reply_starts = 0;
	int reply_done = 0;
	int mon_i;
	logic [NONCE_W-1:0] last_nonce;
	logic [7:0] reply_bits;
	logic [7:0] last_reply;
	logic last_stop;

	miner_ctrl_top #(
		.CLKS_PER_BIT   (BIT_CLKS),
		.TIMEOUT_CYCLES (TMO_CLKS)
	) DUT (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.rx_i          (rx),
		.tx_o          (tx),
		.running_o     (running),
		.nonce_valid_o (nonce_valid),
		.nonce_o       (nonce)
	);

	always #5 clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles > cycle_limit) begin
			$display("Timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("%0d checks, %0d errors", checks, errors);
			$display("tests failed");
			$finish;
		end
	end

	// Decodes the reply at mid-bit on the falling edge.
	always begin
		@(negedge clk_i);
		if (!rst_i && tx === 1'b0) begin
			reply_starts++;
			repeat (BIT_CLKS / 2) @(negedge clk_i);
			for (mon_i = 0; mon_i < 8; mon_i++) begin
				repeat (BIT_CLKS) @(negedge clk_i);
				reply_bits[mon_i] = tx;
			end
			repeat (BIT_CLKS) @(negedge clk_i);
			last_stop = tx;
			last_reply = reply_bits;
			reply_done++;
		end
	end

	always @(negedge clk_i) begin
		if (!rst_i && nonce_valid === 1'b1) begin
			last_nonce = nonce;
			nonce_count++;
		end
	end

	task automatic expect_true(input logic ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("FAILED %0t: %s", $time, what);
		end
	endtask

	// Data bytes go out after the command text and MSB first.
	task automatic add_test(input string cmd, input logic [31:0] data, input int data_len,
		input int gap_len, input int gap_pos, input logic run,
		input logic has_nonce, input logic [31:0] nonce_val,
		input logic has_reply, input logic [7:0] reply_val);
		int i;
		int n;
		n = 0;
		for (i = 0; i < cmd.len(); i++) begin
			seq[num_tests][n] = cmd[i];
			n++;
		end
		for (i = 0; i < data_len; i++) begin
			seq[num_tests][n] = data[31 - 8*i -: 8];
			n++;
		end
		seq_len[num_tests] = n;
		gap[num_tests] = gap_len;
		gap_at[num_tests] = gap_pos;
		exp_run[num_tests] = run;
		exp_has_nonce[num_tests] = has_nonce;
		exp_nonce[num_tests] = nonce_val;
		exp_has_reply[num_tests] = has_reply;
		exp_reply[num_tests] = reply_val;
		num_tests++;
	endtask

	task automatic build_table();
		add_test("d41", 32'h0, 0, 0, 0, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d40", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d4p", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b1, miner_ctrl_pkg::STATUS_IDLE);
		add_test("d41", 32'h0, 0, 0, 0, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d4p", 32'h0, 0, 0, 0, 1'b1, 1'b0, 32'h0, 1'b1, miner_ctrl_pkg::STATUS_RUN);
		add_test("d4n", 32'hdeadbeef, 4, 0, 0, 1'b1, 1'b1, 32'hdeadbeef, 1'b0, 8'h00);
		add_test("d4n", 32'h01234567, 4, 0, 0, 1'b1, 1'b1, 32'h01234567, 1'b0, 8'h00);
		add_test("d40", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b0, 8'h00);
		// Broken headers.
		add_test("dx1", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("41", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("dd41", 32'h0, 0, 0, 0, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		// Long gaps cancel but short ones do not.
		add_test("d40", 32'h0, 0, 500, 1, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d40", 32'h0, 0, 500, 2, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d40", 32'h0, 0, 200, 1, 1'b0, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d41", 32'h0, 0, 200, 2, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		// Unknown command leaves the engine running.
		add_test("d4x", 32'h0, 0, 0, 0, 1'b1, 1'b0, 32'h0, 1'b0, 8'h00);
		add_test("d40", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b0, 8'h00);
		// Command codes '1' 'p' 'd' '4' as nonce data.
		add_test("d4n1pd4", 32'h0, 0, 0, 0, 1'b0, 1'b1, 32'h31706434, 1'b0, 8'h00);
		add_test("d4p", 32'h0, 0, 0, 0, 1'b0, 1'b0, 32'h0, 1'b1, miner_ctrl_pkg::STATUS_IDLE);
	endtask

	task automatic drive_bit(input logic value);
		rx <= value;
		repeat (BIT_CLKS) @(posedge clk_i);
	endtask

	task automatic send_byte(input logic [7:0] value);
		int i;
		drive_bit(1'b0);
		for (i = 0; i < 8; i++)
			drive_bit(value[i]);
		drive_bit(1'b1); // Stop bit.
		drive_bit(1'b1);
		drive_bit(1'b1);
	endtask

	initial begin
		int t;
		int i;
		int total;
		int starts_before;
		int done_before;
		int nonces_before;
		clk_i = 1'b0;
		rst_i = 1'b1;
		rx = 1'b1;
		build_table();
		total = 0;
		for (t = 0; t < num_tests; t++)
			total = total + seq_len[t] * 12 * BIT_CLKS + gap[t];
		cycle_limit = 2 * total + RESET_CLKS;

		repeat (RESET_CLKS) @(posedge clk_i);
		rst_i <= 1'b0;
		@(posedge clk_i);

		for (t = 0; t < num_tests; t++) begin
			starts_before = reply_starts;
			done_before = reply_done;
			nonces_before = nonce_count;
			for (i = 0; i < seq_len[t]; i++) begin
				if (gap[t] > 0 && i == gap_at[t])
					repeat (gap[t]) @(posedge clk_i);
				send_byte(seq[t][i]);
			end
			if (exp_has_reply[t]) begin
				while (reply_done == done_before)
					@(posedge clk_i);
			end
			@(negedge clk_i);
			expect_true(running === exp_run[t],
				$sformatf("test %0d: running %b, expected %b", t, running, exp_run[t]));
			if (exp_has_nonce[t]) begin
				expect_true(nonce_count == nonces_before + 1,
					$sformatf("test %0d: %0d nonce pulses, expected 1", t,
					nonce_count - nonces_before));
				expect_true(last_nonce === exp_nonce[t],
					$sformatf("test %0d: nonce %h, expected %h", t, last_nonce, exp_nonce[t]));
			end else begin
				expect_true(nonce_count == nonces_before,
					$sformatf("test %0d: unexpected nonce pulse", t));
			end
			if (exp_has_reply[t]) begin
				expect_true(reply_starts == starts_before + 1,
					$sformatf("test %0d: %0d replies, expected 1", t, reply_starts - starts_before));
				expect_true(last_reply === exp_reply[t],
					$sformatf("test %0d: reply %h, expected %h", t, last_reply, exp_reply[t]));
				expect_true(last_stop === 1'b1, $sformatf("test %0d: reply stop bit low", t));
			end else begin
				expect_true(reply_starts == starts_before,
					$sformatf("test %0d: unexpected reply", t));
			end
			@(posedge clk_i);
		end

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: miner_ctrl_top.sv
`timescale 1ns/1ps
`default_nettype none

module miner_ctrl_top #(
	parameter int CLKS_PER_BIT   = 16,
	parameter int TIMEOUT_CYCLES = 4096
) (
	input  logic                                  clk_i,
	input  logic                                  rst_i,
	input  logic                                  rx_i,
	output logic                                  tx_o,
	output logic                                  running_o,
	output logic                                  nonce_valid_o,
	output logic [miner_ctrl_pkg::NONCE_BYTES*8-1:0] nonce_o
);

	logic       byte_valid;
	logic [7:0] byte_data;
	logic       tmo_restart;
	logic       tmo_expired;
	logic       nonce_load;
	logic       nonce_ready;
	logic       cmd_start;
	logic       cmd_stop;
	logic       cmd_ping;

	uart_rx #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_uart_rx (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.rx_i         (rx_i),
		.byte_valid_o (byte_valid),
		.byte_data_o  (byte_data)
	);

	byte_timeout #(
		.TIMEOUT_CYCLES(TIMEOUT_CYCLES)
	) u_byte_timeout (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.restart_i (tmo_restart),
		.expired_o (tmo_expired)
	);

	receiver u_receiver (
		.clk_i                   (clk_i),
		.rst_i                   (rst_i),
		.new_data_i              (byte_valid),
		.data_i                  (byte_data),
		.timed_out_i             (tmo_expired),
		.nonce_register_ready_i  (nonce_ready),
		.timeout_counter_reset_o (tmo_restart),
		.start_o                 (cmd_start),
		.stop_o                  (cmd_stop),
		.ping_o                  (cmd_ping),
		.nonce_o                 (nonce_load)
	);

	nonce_register u_nonce_register (
		.clk_i         (clk_i),
		.rst_i         (rst_i),
		.load_i        (nonce_load),
		.byte_valid_i  (byte_valid),
		.byte_data_i   (byte_data),
		.ready_o       (nonce_ready),
		.nonce_valid_o (nonce_valid_o),
		.nonce_o       (nonce_o)
	);

	status_reply #(
		.CLKS_PER_BIT(CLKS_PER_BIT)
	) u_status_reply (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.start_i   (cmd_start),
		.stop_i    (cmd_stop),
		.ping_i    (cmd_ping),
		.running_o (running_o),
		.tx_o      (tx_o)
	);

endmodule

`default_nettype wire

// File: status_reply.sv
`timescale 1ns/1ps
`default_nettype none

module status_reply #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic start_i,
	input  logic stop_i,
	input  logic ping_i,
	output logic running_o,
	output logic tx_o
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	logic busy;
	logic [CNT_W-1:0] cnt;
	logic [3:0] bit_idx;
	logic [9:0] frame_q;
	logic [7:0] reply;

	assign reply = running_o ? miner_ctrl_pkg::STATUS_RUN : miner_ctrl_pkg::STATUS_IDLE;
	assign tx_o = frame_q[0];

	always_ff @(posedge clk_i) begin
		if (rst_i)
			running_o <= 1'b0;
		else if (start_i)
			running_o <= 1'b1;
		else if (stop_i)
			running_o <= 1'b0;
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			busy <= 1'b0;
			cnt <= '0;
			bit_idx <= '0;
			frame_q <= '1; // Idle line.
		end else if (!busy) begin
			if (ping_i) begin
				busy <= 1'b1;
				cnt <= '0;
				bit_idx <= '0;
				frame_q <= {1'b1, reply, 1'b0}; // Stop, data, start.
			end
		end else if (cnt == FULL_BIT) begin
			cnt <= '0;
			frame_q <= {1'b1, frame_q[9:1]};
			if (bit_idx == 4'd9)
				busy <= 1'b0;
			else
				bit_idx <= bit_idx + 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

// File: nonce_register.sv
`timescale 1ns/1ps
`default_nettype none

module nonce_register (
	input  logic                                  clk_i,
	input  logic                                  rst_i,
	input  logic                                  load_i,
	input  logic                                  byte_valid_i,
	input  logic [7:0]                            byte_data_i,
	output logic                                  ready_o,
	output logic                                  nonce_valid_o,
	output logic [miner_ctrl_pkg::NONCE_BYTES*8-1:0] nonce_o
);

	localparam int W = miner_ctrl_pkg::NONCE_BYTES * 8;
	localparam int CNT_W = $clog2(miner_ctrl_pkg::NONCE_BYTES + 1);
	localparam logic [CNT_W-1:0] LAST = CNT_W'(miner_ctrl_pkg::NONCE_BYTES - 1);

	logic armed;
	logic [CNT_W-1:0] count;
	logic [W-1:0] shift_q;
	logic take;
	logic last_byte;

	assign take = armed && byte_valid_i && !load_i;
	assign last_byte = take && (count == LAST);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			armed <= 1'b0;
			count <= '0;
			ready_o <= 1'b0;
			nonce_valid_o <= 1'b0;
		end else begin
			ready_o <= last_byte;
			nonce_valid_o <= last_byte;
			if (load_i) begin
				armed <= 1'b1;
				count <= '0;
			end else if (last_byte) begin
				armed <= 1'b0;
			end else if (take) begin
				count <= count + 1'b1;
			end
		end
	end

	// First byte ends up on top.
	always_ff @(posedge clk_i) begin
		if (load_i)
			shift_q <= '0;
		else if (take)
			shift_q <= {shift_q[W-9:0], byte_data_i};
	end

	always_ff @(posedge clk_i) begin
		if (last_byte)
			nonce_o <= {shift_q[W-9:0], byte_data_i};
	end

endmodule

`default_nettype wire

// File: receiver.sv
`timescale 1ns/1ps
`default_nettype none

module receiver (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       new_data_i,
	input  logic [7:0] data_i,
	input  logic       timed_out_i,
	input  logic       nonce_register_ready_i,
	output logic       timeout_counter_reset_o,
	output logic       start_o,
	output logic       stop_o,
	output logic       ping_o,
	output logic       nonce_o
);

	typedef enum logic [1:0] {
		FIRST_HEADER,
		SECOND_HEADER,
		COMMAND,
		NONCE_WAIT
	} state_t;

	state_t state, nextstate;

	always_comb begin
		timeout_counter_reset_o = 1'b0;
		start_o = 1'b0;
		stop_o = 1'b0;
		ping_o = 1'b0;
		nonce_o = 1'b0;
		nextstate = state;

		case (state)
			FIRST_HEADER: begin
				if (new_data_i && data_i == miner_ctrl_pkg::HDR_FIRST) begin
					timeout_counter_reset_o = 1'b1;
					nextstate = SECOND_HEADER;
				end
			end
			SECOND_HEADER: begin
				if (timed_out_i) begin
					nextstate = FIRST_HEADER;
				end else if (new_data_i) begin
					if (data_i == miner_ctrl_pkg::HDR_SECOND) begin
						timeout_counter_reset_o = 1'b1;
						nextstate = COMMAND;
					end else if (data_i == miner_ctrl_pkg::HDR_FIRST) begin
						timeout_counter_reset_o = 1'b1; // Repeated 'd' keeps the header.
					end else begin
						nextstate = FIRST_HEADER;
					end
				end
			end
			COMMAND: begin
				if (timed_out_i) begin
					nextstate = FIRST_HEADER;
				end else if (new_data_i) begin
					nextstate = FIRST_HEADER;
					case (data_i)
						miner_ctrl_pkg::CMD_NONCE: begin
							nonce_o = 1'b1;
							nextstate = NONCE_WAIT;
						end
						miner_ctrl_pkg::CMD_STOP:  stop_o = 1'b1;
						miner_ctrl_pkg::CMD_START: start_o = 1'b1;
						miner_ctrl_pkg::CMD_PING:  ping_o = 1'b1;
						default: ; // Unknown command.
					endcase
				end
			end
			NONCE_WAIT: begin
				// Bytes belong to the nonce register here.
				if (nonce_register_ready_i)
					nextstate = FIRST_HEADER;
			end
			default: nextstate = FIRST_HEADER;
		endcase
	end

	always_ff @(posedge clk_i) begin
		if (rst_i)
			state <= FIRST_HEADER;
		else
			state <= nextstate;
	end

endmodule

`default_nettype wire

// File: byte_timeout.sv
`timescale 1ns/1ps
`default_nettype none

module byte_timeout #(
	parameter int TIMEOUT_CYCLES = 4096
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic restart_i,
	output logic expired_o
);

	localparam int CNT_W = $clog2(TIMEOUT_CYCLES + 1);
	localparam logic [CNT_W-1:0] LIMIT = CNT_W'(TIMEOUT_CYCLES);

	logic [CNT_W-1:0] cnt;

	// Saturates at the limit.
	always_ff @(posedge clk_i) begin
		if (rst_i || restart_i)
			cnt <= '0;
		else if (cnt != LIMIT)
			cnt <= cnt + 1'b1;
	end

	assign expired_o = (cnt == LIMIT);

endmodule

`default_nettype wire

// File: uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLKS_PER_BIT = 16
) (
	input  logic       clk_i,
	input  logic       rst_i,
	input  logic       rx_i,
	output logic       byte_valid_o,
	output logic [7:0] byte_data_o
);

	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	typedef enum logic [1:0] {IDLE, START, DATA, STOP} state_t;

	state_t state;
	logic [1:0] sync_q;
	logic rx_s;
	logic rx_prev;
	logic [CNT_W-1:0] cnt;
	logic [2:0] bit_idx;
	logic [7:0] shift_q;
	logic data_sample;

	assign rx_s = sync_q[1];
	assign data_sample = (state == DATA) && (cnt == FULL_BIT);
	assign byte_data_o = shift_q;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			sync_q <= 2'b11; // Line idles high.
			rx_prev <= 1'b1;
		end else begin
			sync_q <= {sync_q[0], rx_i};
			rx_prev <= rx_s;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state <= IDLE;
			cnt <= '0;
			bit_idx <= '0;
			byte_valid_o <= 1'b0;
		end else begin
			byte_valid_o <= 1'b0;
			case (state)
				IDLE: begin
					if (rx_prev && !rx_s) begin
						state <= START;
						cnt <= '0;
					end
				end
				START: begin
					if (cnt == HALF_BIT) begin
						cnt <= '0;
						bit_idx <= '0;
						state <= rx_s ? IDLE : DATA; // Glitch if high at mid-bit.
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				DATA: begin
					if (cnt == FULL_BIT) begin
						cnt <= '0;
						if (bit_idx == 3'd7)
							state <= STOP;
						else
							bit_idx <= bit_idx + 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				STOP: begin
					if (cnt == FULL_BIT) begin
						state <= IDLE;
						byte_valid_o <= rx_s; // Low stop bit drops the frame.
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// LSB arrives first.
	always_ff @(posedge clk_i) begin
		if (data_sample)
			shift_q <= {rx_s, shift_q[7:1]};
	end

endmodule

`default_nettype wire

// File: miner_ctrl_pkg.sv
`default_nettype none

package miner_ctrl_pkg;

	// Header bytes, 'd' then '4'.
	localparam logic [7:0] HDR_FIRST  = 8'd100;
	localparam logic [7:0] HDR_SECOND = 8'd52;

	// Command bytes.
	localparam logic [7:0] CMD_NONCE = 8'd110; // 'n'
	localparam logic [7:0] CMD_STOP  = 8'd48;  // '0'
	localparam logic [7:0] CMD_START = 8'd49;  // '1'
	localparam logic [7:0] CMD_PING  = 8'd112; // 'p'

	// Ping replies.
	localparam logic [7:0] STATUS_RUN  = 8'd49; // '1'
	localparam logic [7:0] STATUS_IDLE = 8'd48; // '0'

	// Nonce size in bytes, sent MSB first.
	localparam int NONCE_BYTES = 4;

endpackage

`default_nettype wire
